// File: hdl/capture_buffer.sv
//////////////////////////////////////////////////////////////////////
// capture buffer: arm/start/stop capture into a memory, then stream
// the stored entries out in write order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module capture_buffer
  import capture_pkg::*;
#(
  parameter type payload_t = logic [15:0],
  parameter int DEPTH = 16
) (
  input  logic                       adc_clk,
  input  logic                       adc_reset,
  // write side
  input  payload_t                   data,
  input  logic                       data_valid,
  // control
  input  logic                       arm,
  input  logic                       hw_start,
  input  logic                       hw_stop,
  input  logic                       readout_start,
  // status
  output logic                       capture_ready,
  output logic                       capture_full,
  output logic [$clog2(DEPTH+1)-1:0] write_depth,
  // readout stream
  output payload_t                   out_data,
  output logic                       out_valid,
  output logic                       out_last,
  input  logic                       out_ready
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int DEPTH_W = $clog2(DEPTH+1);
  localparam logic [DEPTH_W-1:0] FULL_COUNT = DEPTH_W'(DEPTH);

  buffer_state_t state;
  payload_t mem [DEPTH];

  logic [DEPTH_W-1:0] read_ptr;
  logic [DEPTH_W-1:0] read_total;
  logic write_en;
  logic read_en;

  // start/stop are only taken while no captured data is pending
  assign capture_ready = (state != HOLD) && (state != READOUT);
  assign capture_full = (write_depth == FULL_COUNT);

  assign write_en = (state == CAPTURE) && data_valid && !capture_full;

  // an empty capture still produces a single zero word
  assign read_total = (write_depth == '0) ? DEPTH_W'(1) : write_depth;

  // at most one read in flight, issued when the output register frees up
  assign read_en = (state == READOUT) && (read_ptr != read_total)
                   && (!out_valid || out_ready);

  //////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (write_en) begin
      mem[write_depth[ADDR_W-1:0]] <= data;
    end
  end

  // read into the output register
  always_ff @(posedge adc_clk) begin
    if (read_en) begin
      out_data <= (write_depth == '0) ? '0 : mem[read_ptr[ADDR_W-1:0]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // capture and readout FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= IDLE;
      write_depth <= '0;
      read_ptr <= '0;
    end else begin
      case (state)
        IDLE: begin
          // depth of the previous capture stays visible until the next arm
          if (arm) begin
            state <= ARMED;
            write_depth <= '0;
          end
        end
        ARMED: begin
          if (hw_start) begin
            state <= CAPTURE;
          end
        end
        CAPTURE: begin
          if (write_en) begin
            write_depth <= write_depth + 1'b1;
          end
          // the write on the last free entry ends the capture
          if (hw_stop || (write_en && (write_depth == FULL_COUNT - 1'b1))) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (readout_start) begin
            state <= READOUT;
            read_ptr <= '0;
          end
        end
        READOUT: begin
          if (read_en) begin
            read_ptr <= read_ptr + 1'b1;
          end
          if (out_valid && out_ready && out_last) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // output register flags
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else if (read_en) begin
      out_valid <= 1'b1;
      out_last <= (read_ptr == read_total - 1'b1);
    end else if (out_ready) begin
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/capture_defs.svh
//////////////////////////////////////////////////////////////////////
// capture buffer definitions
// payload widths, memory depths and discriminator latency
//////////////////////////////////////////////////////////////////////

`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// payload widths in bits
`define SAMPLE_WIDTH 16
`define TSTAMP_WIDTH 32
`define READOUT_WIDTH 64

// memory depths in entries
`define SAMPLE_DEPTH 64
`define TSTAMP_DEPTH 16

// cycles from discriminator reset until its timestamps are valid
`define DISC_LATENCY 4

`endif

// File: hdl/capture_pkg.sv
//////////////////////////////////////////////////////////////////////
// capture types: payload words, readout word and buffer state
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "capture_defs.svh"

package capture_pkg;

  // payloads written into the two capture memories
  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`TSTAMP_WIDTH-1:0] tstamp_t;

  // packed word on the readout stream
  typedef logic [`READOUT_WIDTH-1:0] readout_t;

  // capture buffer FSM
  typedef enum logic [2:0] {IDLE, ARMED, CAPTURE, HOLD, READOUT} buffer_state_t;

endpackage

`default_nettype wire

// File: hdl/readout_mux.sv
//////////////////////////////////////////////////////////////////////
// readout mux: timestamp segment first, then the sample segment
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module readout_mux
  import capture_pkg::*;
(
  input  logic     adc_clk,
  input  logic     adc_reset,
  // timestamp stream
  input  readout_t tstamp_data,
  input  logic     tstamp_valid,
  input  logic     tstamp_last,
  output logic     tstamp_ready,
  // sample stream
  input  readout_t sample_data,
  input  logic     sample_valid,
  input  logic     sample_last,
  output logic     sample_ready,
  // merged readout
  output readout_t readout_data,
  output logic     readout_valid,
  output logic     readout_last,
  input  logic     readout_ready
);

  typedef enum logic {SEL_TSTAMP, SEL_SAMPLE} select_t;

  select_t sel;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      sel <= SEL_TSTAMP;
    end else begin
      case (sel)
        SEL_TSTAMP: if (tstamp_valid && tstamp_ready && tstamp_last) sel <= SEL_SAMPLE;
        SEL_SAMPLE: if (sample_valid && sample_ready && sample_last) sel <= SEL_TSTAMP;
        default: sel <= SEL_TSTAMP;
      endcase
    end
  end

  // timestamp last is held back so one last closes the whole readout
  always_comb begin
    if (sel == SEL_SAMPLE) begin
      readout_data = sample_data;
      readout_valid = sample_valid;
      readout_last = sample_last;
    end else begin
      readout_data = tstamp_data;
      readout_valid = tstamp_valid;
      readout_last = 1'b0;
    end
  end

  assign tstamp_ready = (sel == SEL_TSTAMP) && readout_ready;
  assign sample_ready = (sel == SEL_SAMPLE) && readout_ready;

endmodule

`default_nettype wire

// File: hdl/segmented_capture.sv
//////////////////////////////////////////////////////////////////////
// segmented capture: sample and timestamp buffers with shared control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module segmented_capture
  import capture_pkg::*;
(
  input  logic                                adc_clk,
  input  logic                                adc_reset,
  // capture inputs
  input  sample_t                             sample_data,
  input  logic                                sample_valid,
  input  tstamp_t                             tstamp_data,
  input  logic                                tstamp_valid,
  // control pulses
  input  logic                                capture_arm,
  input  logic                                capture_start,
  input  logic                                capture_stop,
  input  logic                                digital_trigger,
  input  logic                                readout_start,
  output logic                                discriminator_reset,
  // status
  output logic [$clog2(`SAMPLE_DEPTH+1)-1:0] samples_write_depth,
  output logic [$clog2(`TSTAMP_DEPTH+1)-1:0] tstamps_write_depth,
  // readout stream
  output readout_t                            readout_data,
  output logic                                readout_valid,
  output logic                                readout_last,
  input  logic                                readout_ready
);

  logic tstamp_capture_ready, sample_capture_ready;
  logic tstamp_full, sample_full;
  logic capture_ready_all;
  logic stop_accepted;
  logic start_q;
  logic [`DISC_LATENCY-1:0] start_pipe;
  logic hw_start;

  tstamp_t tstamp_buf_data;
  logic tstamp_buf_valid, tstamp_buf_last, tstamp_buf_ready;
  sample_t sample_buf_data;
  logic sample_buf_valid, sample_buf_last, sample_buf_ready;

  readout_t tstamp_word_data;
  logic tstamp_word_valid, tstamp_word_last, tstamp_word_ready;
  readout_t sample_word_data;
  logic sample_word_valid, sample_word_last, sample_word_ready;

  //////////////////////////////////////////////////////////////////////
  // start/stop control
  //////////////////////////////////////////////////////////////////////

  // start and stop are dropped while either buffer holds unread data
  assign capture_ready_all = tstamp_capture_ready && sample_capture_ready;
  assign stop_accepted = capture_stop && capture_ready_all;

  // accepted start resets the discriminator, then waits out its latency
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      start_q <= 1'b0;
      start_pipe <= '0;
    end else begin
      start_q <= capture_start && capture_ready_all;
      start_pipe <= {start_pipe[`DISC_LATENCY-2:0], start_q};
    end
  end

  assign discriminator_reset = start_q;
  assign hw_start = start_pipe[`DISC_LATENCY-1] || digital_trigger;

  //////////////////////////////////////////////////////////////////////
  // buffers, stop cross-coupled on full
  //////////////////////////////////////////////////////////////////////

  capture_buffer #(
    .payload_t(tstamp_t),
    .DEPTH(`TSTAMP_DEPTH)
  ) tstamp_buffer_i (
    .adc_clk, .adc_reset,
    .data(tstamp_data), .data_valid(tstamp_valid),
    .arm(capture_arm), .hw_start, .hw_stop(stop_accepted || sample_full), .readout_start,
    .capture_ready(tstamp_capture_ready), .capture_full(tstamp_full),
    .write_depth(tstamps_write_depth),
    .out_data(tstamp_buf_data), .out_valid(tstamp_buf_valid),
    .out_last(tstamp_buf_last), .out_ready(tstamp_buf_ready)
  );

  capture_buffer #(
    .payload_t(sample_t),
    .DEPTH(`SAMPLE_DEPTH)
  ) sample_buffer_i (
    .adc_clk, .adc_reset,
    .data(sample_data), .data_valid(sample_valid),
    .arm(capture_arm), .hw_start, .hw_stop(stop_accepted || tstamp_full), .readout_start,
    .capture_ready(sample_capture_ready), .capture_full(sample_full),
    .write_depth(samples_write_depth),
    .out_data(sample_buf_data), .out_valid(sample_buf_valid),
    .out_last(sample_buf_last), .out_ready(sample_buf_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // packing and readout ordering
  //////////////////////////////////////////////////////////////////////

  word_packer #(.in_t(tstamp_t)) tstamp_packer_i (
    .adc_clk, .adc_reset,
    .in_data(tstamp_buf_data), .in_valid(tstamp_buf_valid),
    .in_last(tstamp_buf_last), .in_ready(tstamp_buf_ready),
    .out_data(tstamp_word_data), .out_valid(tstamp_word_valid),
    .out_last(tstamp_word_last), .out_ready(tstamp_word_ready)
  );

  word_packer #(.in_t(sample_t)) sample_packer_i (
    .adc_clk, .adc_reset,
    .in_data(sample_buf_data), .in_valid(sample_buf_valid),
    .in_last(sample_buf_last), .in_ready(sample_buf_ready),
    .out_data(sample_word_data), .out_valid(sample_word_valid),
    .out_last(sample_word_last), .out_ready(sample_word_ready)
  );

  readout_mux readout_mux_i (
    .adc_clk, .adc_reset,
    .tstamp_data(tstamp_word_data), .tstamp_valid(tstamp_word_valid),
    .tstamp_last(tstamp_word_last), .tstamp_ready(tstamp_word_ready),
    .sample_data(sample_word_data), .sample_valid(sample_word_valid),
    .sample_last(sample_word_last), .sample_ready(sample_word_ready),
    .readout_data, .readout_valid, .readout_last, .readout_ready
  );

endmodule

`default_nettype wire

// File: hdl/word_packer.sv
//////////////////////////////////////////////////////////////////////
// word packer: gathers narrow stream words into one readout word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module word_packer
  import capture_pkg::*;
#(
  parameter type in_t = logic [15:0]
) (
  input  logic     adc_clk,
  input  logic     adc_reset,
  // narrow input stream
  input  in_t      in_data,
  input  logic     in_valid,
  input  logic     in_last,
  output logic     in_ready,
  // packed output stream
  output readout_t out_data,
  output logic     out_valid,
  output logic     out_last,
  input  logic     out_ready
);

  localparam int IN_W = $bits(in_t);
  localparam int RATIO = $bits(readout_t) / IN_W;
  localparam int IDX_W = $clog2(RATIO);

  readout_t acc;
  readout_t acc_next;
  logic [IDX_W-1:0] idx;
  logic accept;
  logic word_done;

  // no new part is taken while a packed word is waiting
  assign in_ready = !out_valid;
  assign accept = in_valid && in_ready;
  assign word_done = in_last || (idx == IDX_W'(RATIO - 1));

  // first word lands in the lowest bits
  always_comb begin
    acc_next = acc;
    acc_next[int'(idx) * IN_W +: IN_W] = in_data;
  end

  always_ff @(posedge adc_clk) begin
    if (accept && word_done) begin
      out_data <= acc_next;
    end
  end

  // accumulator is cleared after each word, which zero-pads a short final word
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      acc <= '0;
      idx <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
      if (accept) begin
        if (word_done) begin
          out_valid <= 1'b1;
          out_last <= in_last;
          acc <= '0;
          idx <= '0;
        end else begin
          acc <= acc_next;
          idx <= idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/capture_pkg.sv
hdl/capture_buffer.sv
hdl/word_packer.sv
hdl/readout_mux.sv
hdl/segmented_capture.sv
testbench/segmented_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module segmented_capture_tb -f project.f &&
./obj_dir/Vsegmented_capture_tb | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/segmented_capture_tb.sv
//////////////////////////////////////////////////////////////////////
// segmented capture testbench: capture, cross-coupled stop, readout
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module segmented_capture_tb
  import capture_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int FILL_TIMEOUT = 100;
  localparam int READOUT_TIMEOUT = 500;
  // capture phase plus fill wait plus readout, per test
  localparam int TEST_CYCLES = 60 + FILL_TIMEOUT + READOUT_TIMEOUT;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 5 * TEST_CYCLES + 200;

  localparam int CTRL_ARM = 0;
  localparam int CTRL_START = 1;
  localparam int CTRL_STOP = 2;
  localparam int CTRL_TRIGGER = 3;
  localparam int CTRL_READOUT = 4;

  logic adc_clk;
  logic adc_reset;
  sample_t sample_data;
  logic sample_valid;
  tstamp_t tstamp_data;
  logic tstamp_valid;
  logic capture_arm;
  logic capture_start;
  logic capture_stop;
  logic digital_trigger;
  logic readout_start;
  logic discriminator_reset;
  logic [$clog2(`SAMPLE_DEPTH+1)-1:0] samples_write_depth;
  logic [$clog2(`TSTAMP_DEPTH+1)-1:0] tstamps_write_depth;
  readout_t readout_data;
  logic readout_valid;
  logic readout_last;
  logic readout_ready;

  // stimulus modes, changed only on a clock edge
  logic tstamp_every_cycle;
  logic random_ready;
  int seed = 65;
  int rand_word;

  // readout monitor state
  readout_t readout_words[$];
  bit readout_lasts[$];
  int disc_pulses;
  bit held_valid;
  readout_t held_data;
  logic held_last;

  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;

  segmented_capture uut (
    .adc_clk, .adc_reset,
    .sample_data, .sample_valid, .tstamp_data, .tstamp_valid,
    .capture_arm, .capture_start, .capture_stop, .digital_trigger, .readout_start,
    .discriminator_reset, .samples_write_depth, .tstamps_write_depth,
    .readout_data, .readout_valid, .readout_last, .readout_ready
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // check helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    test_checks++;
    assert (got === exp) else begin
      test_errors++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    test_checks++;
    assert (cond) else begin
      test_errors++;
      $display("%s", what);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and monitor
  //////////////////////////////////////////////////////////////////////

  // samples every cycle, timestamps on random cycles, counters advance per word
  always @(posedge adc_clk) begin
    rand_word = $random(seed);
    if (adc_reset) begin
      sample_valid <= 1'b0;
      tstamp_valid <= 1'b0;
      readout_ready <= 1'b1;
    end else begin
      sample_valid <= 1'b1;
      if (sample_valid) begin
        sample_data <= sample_data + 16'd1;
      end
      if (tstamp_valid) begin
        tstamp_data <= tstamp_data + 32'd1;
      end
      tstamp_valid <= tstamp_every_cycle || rand_word[0];
      readout_ready <= random_ready ? rand_word[1] : 1'b1;
    end
  end

  // data and last must hold while the readout is stalled
  always @(posedge adc_clk) begin
    if (!adc_reset) begin
      if (held_valid) begin
        check_value("readout_data", readout_data, held_data);
        check_value("readout_last", readout_last, held_last);
      end
      if (readout_valid && readout_ready) begin
        readout_words.push_back(readout_data);
        readout_lasts.push_back(readout_last);
      end
      if (discriminator_reset) begin
        disc_pulses++;
      end
    end
    held_valid = readout_valid && !readout_ready;
    held_data = readout_data;
    held_last = readout_last;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic pulse_control(input int which);
    @(posedge adc_clk);
    case (which)
      CTRL_ARM: capture_arm <= 1'b1;
      CTRL_START: capture_start <= 1'b1;
      CTRL_STOP: capture_stop <= 1'b1;
      CTRL_TRIGGER: digital_trigger <= 1'b1;
      default: readout_start <= 1'b1;
    endcase
    @(posedge adc_clk);
    capture_arm <= 1'b0;
    capture_start <= 1'b0;
    capture_stop <= 1'b0;
    digital_trigger <= 1'b0;
    readout_start <= 1'b0;
  endtask

  // unpack the collected words and compare with the captured depths
  task automatic check_stream(input int td, input int sd);
    int tw;
    int sw;
    int k;
    readout_t word;
    tstamp_t t_first;
    tstamp_t t_val;
    sample_t s_first;
    sample_t s_val;
    tw = (td == 0) ? 1 : (td * `TSTAMP_WIDTH + `READOUT_WIDTH - 1) / `READOUT_WIDTH;
    sw = (sd == 0) ? 1 : (sd * `SAMPLE_WIDTH + `READOUT_WIDTH - 1) / `READOUT_WIDTH;
    check_value("readout word count", readout_words.size(), tw + sw);
    if (readout_words.size() == tw + sw) begin
      for (k = 0; k < tw + sw; k++) begin
        check_value("readout_last", readout_lasts[k], k == tw + sw - 1);
      end
      // timestamp segment comes first
      word = readout_words[0];
      t_first = word[`TSTAMP_WIDTH-1:0];
      for (k = 0; k < tw * 2; k++) begin
        word = readout_words[k / 2];
        t_val = word[(k % 2) * `TSTAMP_WIDTH +: `TSTAMP_WIDTH];
        if (k < td) begin
          check_value("readout_data timestamp", t_val, t_first + k);
        end else begin
          check_value("readout_data timestamp pad", t_val, '0);
        end
      end
      word = readout_words[tw];
      s_first = word[`SAMPLE_WIDTH-1:0];
      for (k = 0; k < sw * 4; k++) begin
        word = readout_words[tw + k / 4];
        s_val = word[(k % 4) * `SAMPLE_WIDTH +: `SAMPLE_WIDTH];
        if (k < sd) begin
          check_value("readout_data sample", s_val, sample_t'(s_first + k[15:0]));
        end else begin
          check_value("readout_data sample pad", s_val, '0);
        end
      end
    end
  endtask

  task automatic readout_and_check(input int td, input int sd, input bit stall);
    int n;
    readout_words.delete();
    readout_lasts.delete();
    random_ready <= stall;
    pulse_control(CTRL_READOUT);
    n = 0;
    while (!(readout_valid && readout_ready && readout_last) && n < READOUT_TIMEOUT) begin
      @(posedge adc_clk);
      n++;
    end
    check_true(n < READOUT_TIMEOUT, "readout never delivered its last word");
    // let the monitor take the final word
    @(posedge adc_clk);
    random_ready <= 1'b0;
    check_stream(td, sd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int td;
    int sd;
    int n;
    adc_clk = 1'b0;
    adc_reset = 1'b1;
    sample_data = '0;
    sample_valid = 1'b0;
    tstamp_data = '0;
    tstamp_valid = 1'b0;
    capture_arm = 1'b0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    digital_trigger = 1'b0;
    readout_start = 1'b0;
    readout_ready = 1'b1;
    tstamp_every_cycle = 1'b0;
    random_ready = 1'b0;
    disc_pulses = 0;
    test_checks = 0;
    test_errors = 0;
    total_checks = 0;
    total_errors = 0;

    // test 1: outputs come out of reset cleared
    repeat (RESET_CYCLES) @(posedge adc_clk);
    adc_reset <= 1'b0;
    @(posedge adc_clk);
    check_value("readout_valid", readout_valid, 1'b0);
    check_value("readout_last", readout_last, 1'b0);
    check_value("discriminator_reset", discriminator_reset, 1'b0);
    check_value("samples_write_depth", samples_write_depth, '0);
    check_value("tstamps_write_depth", tstamps_write_depth, '0);
    finish_test("test 1 reset");

    // test 2: software start and stop
    disc_pulses = 0;
    pulse_control(CTRL_ARM);
    pulse_control(CTRL_START);
    wait_cycles(16);
    pulse_control(CTRL_STOP);
    wait_cycles(3);
    td = tstamps_write_depth;
    sd = samples_write_depth;
    check_true(sd > 0, "no samples were captured after a software start");
    check_value("discriminator_reset pulses", disc_pulses, 1);
    readout_and_check(td, sd, 1'b0);
    finish_test("test 2 start/stop capture");

    // test 3: full timestamp buffer stops the sample buffer
    tstamp_every_cycle <= 1'b1;
    pulse_control(CTRL_ARM);
    pulse_control(CTRL_START);
    n = 0;
    while (tstamps_write_depth != `TSTAMP_DEPTH && n < FILL_TIMEOUT) begin
      @(posedge adc_clk);
      n++;
    end
    check_true(n < FILL_TIMEOUT, "timestamp buffer never filled");
    wait_cycles(3);
    td = tstamps_write_depth;
    sd = samples_write_depth;
    check_value("tstamps_write_depth", td, `TSTAMP_DEPTH);
    check_true(sd <= `TSTAMP_DEPTH + 1,
               $sformatf("sample depth %0d ran past the timestamp depth plus one", sd));
    tstamp_every_cycle <= 1'b0;
    readout_and_check(td, sd, 1'b0);
    finish_test("test 3 cross-coupled stop");

    // test 4: digital trigger, then readout under back-pressure
    disc_pulses = 0;
    pulse_control(CTRL_ARM);
    pulse_control(CTRL_TRIGGER);
    wait_cycles(20);
    pulse_control(CTRL_STOP);
    wait_cycles(3);
    td = tstamps_write_depth;
    sd = samples_write_depth;
    check_true(sd > 0, "capture did not begin after the digital trigger");
    check_value("discriminator_reset pulses", disc_pulses, 0);
    readout_and_check(td, sd, 1'b1);
    finish_test("test 4 trigger and back-pressure");

    // test 5: start while data is held must be dropped
    pulse_control(CTRL_ARM);
    pulse_control(CTRL_TRIGGER);
    wait_cycles(12);
    pulse_control(CTRL_STOP);
    wait_cycles(3);
    td = tstamps_write_depth;
    sd = samples_write_depth;
    disc_pulses = 0;
    pulse_control(CTRL_START);
    wait_cycles(`DISC_LATENCY + 4);
    check_value("tstamps_write_depth", tstamps_write_depth, td);
    check_value("samples_write_depth", samples_write_depth, sd);
    check_value("discriminator_reset pulses", disc_pulses, 0);
    readout_and_check(td, sd, 1'b0);
    finish_test("test 5 ignored start");

    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
